/* all.f */
hdl/knight_pkg.sv
hdl/move_ctrl_if.sv
hdl/cmd_fsm.sv
hdl/square_counter.sv
hdl/frwrd_ramp.sv
hdl/heading_err.sv
hdl/cmd_proc.sv
sim/tb_clk_gen.sv
sim/cmd_proc_checker.sv
sim/cmd_proc_tb.sv

/* sim/cmd_proc_tb.sv */
`timescale 1ns/1ps

module cmd_proc_tb import knight_pkg::*; ();

  localparam int N_MOVES     = 6;    // Random full moves
  localparam int BUDGET_RST  = 10;   // Reset and settling
  localparam int BUDGET_CAL  = 40;   // Up to 16 cycles waiting on the gyro
  localparam int BUDGET_TOUR = 40;   // Tour plus 20 quiet cycles
  localparam int BUDGET_HDG  = 200;  // Short move then 20 IR steps of 3 cycles
  localparam int BUDGET_MOVE = 400;  // Up to 14 line pulses of 8 cycles plus ramp down
  localparam int CYCLE_LIMIT = BUDGET_RST + BUDGET_CAL + BUDGET_TOUR + BUDGET_HDG
                               + N_MOVES * BUDGET_MOVE;

  logic     clk;
  logic     rst_n;
  cmd_t     cmd;
  logic     cmd_rdy;
  logic     cal_done;
  heading_t heading;
  logic     heading_rdy;
  logic     lftIR;
  logic     cntrIR;
  logic     rghtIR;
  logic     clr_cmd_rdy;
  logic     send_resp;
  logic     strt_cal;
  logic     moving;
  heading_t error;
  frwrd_t   frwrd;
  logic     tour_go;
  logic     fanfare_go;

  logic [15:0] lfsr = 16'd56786;  // Galois LFSR state
  int          cycles   = 0;
  int          n_checks = 0;
  int          n_errs   = 0;
  int          n_tests  = 0;
  logic        hdg_hold;     // Heading tracks the desired heading
  heading_t    hdg_off;      // Offset from desired while held
  heading_t    hdg_drv;      // Heading driven this cycle
  heading_t    desired_mdl;  // Desired heading of the last move

  tb_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

  cmd_proc uut (.*);

  ////////////////////////////////////////
  // Random bits and reference model
  ////////////////////////////////////////
  function automatic logic [15:0] rnd(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // One step per bit
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  // Left nudge wins over right, sum wraps in 12 bits
  function automatic heading_t err_model(heading_t hdg, heading_t des, logic l, logic r);
    heading_t nud;
    nud = l ? 12'sh05F : (r ? -12'sh05F : 12'sh000);
    return hdg - des + nud;
  endfunction

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errs++;
      $display("ERR %0s exp 0x%h act 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  // Rising edge, then the free running gyro inputs
  task automatic tick();
    @(posedge clk);
    heading_rdy <= (rnd(2) == 16'd3);  // About one cycle in four
    if (hdg_hold)
      hdg_drv = desired_mdl + hdg_off;
    else
      hdg_drv = heading_t'(rnd(12));
    heading <= hdg_drv;
  endtask

  task automatic test_done(input string name, input int errs_before);
    n_tests++;
    $display("test %0s finished, %0d errors", name, n_errs - errs_before);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_cal();
    int e0;
    int wait_n;
    e0 = n_errs;
    wait_n = rnd(4) + 1;
    tick();
    cmd <= {4'h2, 12'(rnd(12))};
    cmd_rdy <= 1'b1;
    @(negedge clk);
    check("clr_cmd_rdy", 1, clr_cmd_rdy);
    check("strt_cal", 1, strt_cal);
    tick();
    cmd_rdy <= 1'b0;
    repeat (wait_n) begin
      @(negedge clk);
      check("send_resp", 0, send_resp);
      tick();
    end
    cal_done <= 1'b1;              // Gyro reports done
    @(negedge clk);
    check("send_resp", 1, send_resp);
    tick();
    cal_done <= 1'b0;
    @(negedge clk);
    check("send_resp", 0, send_resp);
    test_done("calibration", e0);
  endtask

  task automatic test_tour();
    int         e0;
    logic [3:0] op;
    e0 = n_errs;
    tick();
    cmd <= {4'h6, 12'(rnd(12))};
    cmd_rdy <= 1'b1;
    @(negedge clk);
    check("clr_cmd_rdy", 1, clr_cmd_rdy);
    check("tour_go", 0, tour_go);
    tick();
    cmd_rdy <= 1'b0;
    @(negedge clk);
    check("tour_go", 1, tour_go);  // Exactly one cycle after acceptance
    check("send_resp", 0, send_resp);
    repeat (5) begin
      tick();
      @(negedge clk);
      check("tour_go", 0, tour_go);
      check("send_resp", 0, send_resp);
    end
    op = 4'h2;
    while (op inside {4'h2, 4'h4, 4'h5, 4'h6})
      op = 4'(rnd(4));             // Any opcode the FSM does not know
    tick();
    cmd <= {op, 12'(rnd(12))};
    cmd_rdy <= 1'b1;
    @(negedge clk);
    check("clr_cmd_rdy", 1, clr_cmd_rdy);
    check("strobes", 0, {send_resp, strt_cal, moving, tour_go, fanfare_go});
    tick();
    cmd_rdy <= 1'b0;
    repeat (20) begin
      @(negedge clk);
      check("strobes", 0, {clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go});
      tick();
    end
    test_done("tour and unknown opcode", e0);
  endtask

  // Whole move, from acceptance to the response, with the speed checks
  task automatic run_move(input logic [3:0] op, input sq_cnt_t sq, input logic [7:0] hb);
    int       np8;
    int       t_done;
    logic     resp_seen;
    logic     resp_exp;
    logic     prev_rdy;
    frwrd_t   frwrd_mdl;
    heading_t err_exp;
    np8 = 16 * int'(sq);           // Two lines per square, 8 cycles per line
    t_done = (sq == 3'd0) ? 0 : np8 - 5;  // Last line counted three clocks after its rise
    resp_seen = 1'b0;
    prev_rdy = 1'b0;
    frwrd_mdl = '0;
    tick();
    lftIR <= 1'b0;
    rghtIR <= 1'b0;
    cntrIR <= 1'b0;
    desired_mdl = (hb == 8'h00) ? 12'sh000 : heading_t'({hb, 4'hF});
    hdg_off = 12'sh100;            // Start well outside the window
    hdg_hold = 1'b1;
    tick();
    cmd <= {op, hb, 1'b0, sq};
    cmd_rdy <= 1'b1;
    @(negedge clk);
    check("clr_cmd_rdy", 1, clr_cmd_rdy);
    tick();
    cmd_rdy <= 1'b0;
    cmd <= rnd(16);                // Move fields already captured
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      err_exp = err_model(hdg_drv, desired_mdl, 1'b0, 1'b0);
      check("error", err_exp, error);
      check("moving", (err_exp > -12'sh02C) && (err_exp < 12'sh02C), moving);
      if (i == 2)
        hdg_off = heading_t'($signed(5'(rnd(5))));  // Small offset, inside the window
      if (i == 3)
        hdg_hold = 1'b0;
      tick();
    end
    for (int k = 0; !resp_seen; k++) begin
      cntrIR <= (k < np8) && (k % 8 < 4);
      if (k == 0)
        frwrd_mdl = '0;            // Cleared as the move starts
      else if (prev_rdy && k <= t_done + 1)
        frwrd_mdl = (frwrd_mdl >= 10'h300) ? frwrd_mdl : frwrd_mdl + 10'h020;
      else if (prev_rdy)
        frwrd_mdl = (frwrd_mdl > 10'h040) ? frwrd_mdl - 10'h040 : 10'h000;
      resp_exp = (k > t_done) && (frwrd_mdl == 10'h000);  // Stopped while ramping down
      @(negedge clk);
      check("frwrd", frwrd_mdl, frwrd);
      check("fanfare_go", (op == 4'h5) && (k == t_done), fanfare_go);
      check("send_resp", resp_exp, send_resp);
      if (k != t_done)
        check("moving", !resp_exp, moving);
      resp_seen = resp_exp || send_resp;
      prev_rdy = heading_rdy;      // Steps the speed at the next edge
      tick();
    end
    @(negedge clk);
    check("send_resp", 0, send_resp);
    check("moving", 0, moving);
  endtask

  task automatic test_heading();
    int       e0;
    logic     l;
    logic     r;
    heading_t err_exp;
    e0 = n_errs;
    run_move(4'h4, 3'd0, 8'(rnd(8)));
    for (int i = 0; i < 20; i++) begin
      l = 1'(rnd(1));
      r = 1'(rnd(1));
      tick();
      lftIR <= l;
      rghtIR <= r;
      repeat (2) tick();           // Through the two synchronizer flops
      @(negedge clk);
      err_exp = err_model(hdg_drv, desired_mdl, l, r);
      check("error", err_exp, error);
    end
    test_done("heading error", e0);
  endtask

  task automatic test_moves();
    int         e0;
    sq_cnt_t    sq;
    logic [3:0] op;
    e0 = n_errs;
    for (int m = 0; m < N_MOVES; m++) begin
      sq = 3'd0;
      while (sq == 3'd0)
        sq = 3'(rnd(3));
      op = {3'b010, 1'(rnd(1))};   // Plain move or move with fanfare
      run_move(op, sq, 8'(rnd(8)));
    end
    test_done("full move and speed ramp", e0);
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////
  initial begin
    cmd = '0;
    cmd_rdy = 1'b0;
    cal_done = 1'b0;
    heading = '0;
    heading_rdy = 1'b0;
    lftIR = 1'b0;
    cntrIR = 1'b0;
    rghtIR = 1'b0;
    hdg_hold = 1'b0;
    hdg_off = '0;
    hdg_drv = '0;
    desired_mdl = '0;
    @(posedge rst_n);
    test_cal();
    test_tour();
    test_heading();
    test_moves();
    repeat (2) tick();
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             n_tests, n_checks, n_errs, uut.u_chk.fail_cnt);
    if (n_errs == 0 && uut.u_chk.fail_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

/* sim/cmd_proc_checker.sv */
`timescale 1ns/1ps

module cmd_proc_checker import knight_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       cmd_rdy,
  input logic       clr_cmd_rdy,
  input logic       send_resp,
  input logic       tour_go,
  input logic       fanfare_go,
  input logic       moving,
  input frwrd_t     frwrd,
  input cmd_state_t state
);

  int fail_cnt = 0;  // Failed assertions so far

  task automatic note_fail(input string what);
    fail_cnt++;
    $error("%s", what);
  endtask

  ////////////////////////////////////////
  // Handshake and single cycle strobes
  ////////////////////////////////////////
  clr_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n) clr_cmd_rdy |-> cmd_rdy)
    else note_fail("clr_cmd_rdy high without cmd_rdy");
  tour_single: assert property (@(posedge clk) disable iff (!rst_n) tour_go |=> !tour_go)
    else note_fail("tour_go high for two cycles");
  fan_single: assert property (@(posedge clk) disable iff (!rst_n) fanfare_go |=> !fanfare_go)
    else note_fail("fanfare_go high for two cycles");
  resp_single: assert property (@(posedge clk) disable iff (!rst_n) send_resp |=> !send_resp)
    else note_fail("send_resp high for two cycles");

  ////////////////////////////////////////
  // Speed ceiling and idle behaviour
  ////////////////////////////////////////
  frwrd_cap: assert property (@(posedge clk) disable iff (!rst_n) frwrd <= 10'h300)
    else note_fail("frwrd above 0x300");
  idle_still: assert property (@(posedge clk) disable iff (!rst_n) (state == IDLE) |-> !moving)
    else note_fail("moving high while idle");

endmodule

bind cmd_proc cmd_proc_checker u_chk (
  .clk(clk), .rst_n(rst_n), .cmd_rdy(cmd_rdy), .clr_cmd_rdy(clr_cmd_rdy),
  .send_resp(send_resp), .tour_go(tour_go), .fanfare_go(fanfare_go),
  .moving(moving), .frwrd(frwrd), .state(u_fsm.state)
);

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    rst_n = 1'b0;               // Held low for 8 cycles
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;               // Released away from the rising edge
  end

endmodule

/* hdl/cmd_proc.sv */
`timescale 1ns/1ps

module cmd_proc import knight_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd,          // Command word from BLE
  input  logic     cmd_rdy,      // Command waiting
  output logic     clr_cmd_rdy,  // Command consumed
  output logic     send_resp,    // Command finished
  output logic     strt_cal,     // Kick gyro calibration
  input  logic     cal_done,     // Gyro finished calibrating
  input  heading_t heading,      // Gyro heading
  input  logic     heading_rdy,  // New gyro reading
  input  logic     lftIR,        // Left line sensor
  input  logic     cntrIR,       // Centre line sensor
  input  logic     rghtIR,       // Right line sensor
  output logic     moving,       // Enables yaw integration
  output heading_t error,        // Heading error to PID
  output frwrd_t   frwrd,        // Forward speed to PID
  output logic     tour_go,      // Kick the tour sequencer
  output logic     fanfare_go    // Kick the piezo fanfare
);

  move_ctrl_if ctrl_if ();  // FSM to data path

  cmd_fsm u_fsm (.clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_rdy(cmd_rdy),
                 .cal_done(cal_done), .clr_cmd_rdy(clr_cmd_rdy),
                 .send_resp(send_resp), .strt_cal(strt_cal), .moving(moving),
                 .tour_go(tour_go), .fanfare_go(fanfare_go), .ctrl(ctrl_if));

  square_counter u_sq (.clk(clk), .rst_n(rst_n), .cmd(cmd), .cntrIR(cntrIR),
                       .ctrl(ctrl_if));

  frwrd_ramp u_ramp (.clk(clk), .rst_n(rst_n), .heading_rdy(heading_rdy),
                     .frwrd(frwrd), .ctrl(ctrl_if));

  heading_err u_err (.clk(clk), .rst_n(rst_n), .cmd(cmd), .heading(heading),
                     .lftIR(lftIR), .rghtIR(rghtIR), .ctrl(ctrl_if));

  assign error = ctrl_if.error;  // PID sees the same error as the FSM

endmodule

/* hdl/heading_err.sv */
`timescale 1ns/1ps

module heading_err import knight_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  cmd_t         cmd,      // Heading in bits 11:4
  input  heading_t     heading,  // Gyro heading
  input  logic         lftIR,    // Left line sensor
  input  logic         rghtIR,   // Right line sensor
  move_ctrl_if.heading ctrl
);

  logic [1:0] ir_meta;      // First stage, [1] left [0] right
  logic [1:0] ir_stable;    // Second stage, same order
  heading_t   nudge;        // Correction for drift off the line
  heading_t   desired_hdg;  // Target heading for this move

  ////////////////////////////////////////
  // Side IR synchronizers
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ir_meta   <= 2'b00;
      ir_stable <= 2'b00;
    end else begin
      ir_meta   <= {lftIR, rghtIR};
      ir_stable <= ir_meta;
    end
  end

  // Left wins when both sensors see a line
  always_comb begin
    if (ir_stable[1])
      nudge = NUDGE_LFT;
    else if (ir_stable[0])
      nudge = NUDGE_RGHT;
    else
      nudge = '0;
  end

  // Command heading is the upper byte, padded with 0xF unless zero
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      desired_hdg <= '0;
    else if (ctrl.load)
      desired_hdg <= (cmd[11:4] == 8'h00) ? '0 : {cmd[11:4], 4'hF};
  end

  assign ctrl.error = heading - desired_hdg + nudge;  // Wraps in 12 bits

endmodule

/* hdl/frwrd_ramp.sv */
`timescale 1ns/1ps

module frwrd_ramp import knight_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      heading_rdy,  // New gyro reading, one cycle
  output frwrd_t    frwrd,        // Forward speed to the PID
  move_ctrl_if.ramp ctrl
);

  logic max_spd;  // Top two bits set, no further ramp up

  assign max_spd   = &frwrd[9:8];
  assign ctrl.zero = (frwrd == '0);

  ////////////////////////////////////////
  // Speed register
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (ctrl.clr_frwrd)
      frwrd <= '0;                      // Start each move from rest
    else if (heading_rdy) begin         // Only step on gyro updates
      if (ctrl.inc_frwrd) begin
        if (!max_spd)
          frwrd <= frwrd + FRWRD_INC;
      end else if (ctrl.dec_frwrd) begin
        if (frwrd > FRWRD_DEC)
          frwrd <= frwrd - FRWRD_DEC;
        else
          frwrd <= '0;                  // Saturate at rest
      end
    end
  end

endmodule

/* hdl/square_counter.sv */
`timescale 1ns/1ps

module square_counter import knight_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  cmd_t         cmd,     // Square count in bits 2:0
  input  logic         cntrIR,  // Centre IR, high over a line
  move_ctrl_if.counter ctrl
);

  logic [2:0] ir_sync;    // [0] meta, [1] stable, [2] one cycle older
  logic       ir_rise;    // Rising edge of the synchronized sensor
  sq_cnt_t    sq_cnt;     // Squares requested
  logic [3:0] pulse_cnt;  // Line edges seen since load

  ////////////////////////////////////////
  // Synchronizer and edge detect
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      ir_sync <= 3'b000;
    else
      ir_sync <= {ir_sync[1:0], cntrIR};  // Shift in the raw sensor
  end

  assign ir_rise = ir_sync[1] & ~ir_sync[2];  // Stable high, older low

  ////////////////////////////////////////
  // Line counting
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      sq_cnt <= '0;
    else if (ctrl.load)
      sq_cnt <= cmd[2:0];  // Squares for this move
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      pulse_cnt <= 4'h0;
    else if (ctrl.load)
      pulse_cnt <= 4'h0;              // Fresh count per move
    else if (ir_rise)
      pulse_cnt <= pulse_cnt + 4'h1;  // One more line crossed
  end

  // Each square has two lines, zero squares is done at once
  assign ctrl.move_done = (pulse_cnt == {sq_cnt, 1'b0});

endmodule

/* hdl/cmd_fsm.sv */
`timescale 1ns/1ps

module cmd_fsm import knight_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd,          // Command word from BLE
  input  logic     cmd_rdy,      // Command waiting
  input  logic     cal_done,     // Gyro finished calibrating
  output logic     clr_cmd_rdy,  // Command consumed
  output logic     send_resp,    // Command finished
  output logic     strt_cal,     // Kick gyro calibration
  output logic     moving,       // Enables yaw integration
  output logic     tour_go,      // Kick the tour sequencer
  output logic     fanfare_go,   // Kick the piezo fanfare
  move_ctrl_if.fsm ctrl
);

  cmd_state_t state;      // Current state
  cmd_state_t nxt_state;  // Next state
  logic [3:0] opcode;     // Command opcode field
  logic       fan_flag;   // Move came with fanfare
  logic       in_win;     // Heading error small enough to roll

  assign opcode = cmd[15:12];

  // Two sided window, strictly inside
  assign in_win = (ctrl.error < ERR_WIN) && (ctrl.error > -ERR_WIN);

  ////////////////////////////////////////
  // State and fanfare registers
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  // Held for the whole move so cmd may change underneath
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      fan_flag <= 1'b0;
    else if (ctrl.load)
      fan_flag <= (opcode == OP_MOVE_FAN);
  end

  ////////////////////////////////////////
  // Transitions and outputs
  ////////////////////////////////////////
  always_comb begin
    nxt_state      = state;
    clr_cmd_rdy    = 1'b0;
    send_resp      = 1'b0;
    strt_cal       = 1'b0;
    moving         = 1'b0;
    tour_go        = 1'b0;
    fanfare_go     = 1'b0;
    ctrl.load      = 1'b0;
    ctrl.clr_frwrd = 1'b0;
    ctrl.inc_frwrd = 1'b0;
    ctrl.dec_frwrd = 1'b0;

    case (state)
      IDLE: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;  // Every command is consumed
          case (opcode)
            OP_CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            OP_TOUR: nxt_state = START_TOUR;
            OP_MOVE, OP_MOVE_FAN: begin
              ctrl.load = 1'b1;  // Latch heading and square count
              nxt_state = MOVE;
            end
            default: nxt_state = IDLE;  // Unknown opcode dropped
          endcase
        end
      end
      START_TOUR: begin
        tour_go   = 1'b1;
        nxt_state = IDLE;
      end
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;
          nxt_state = IDLE;
        end
      end
      MOVE: begin
        if (in_win) begin       // Pointed close enough
          moving         = 1'b1;
          ctrl.clr_frwrd = 1'b1;
          nxt_state      = INCR;
        end
      end
      INCR: begin
        ctrl.inc_frwrd = 1'b1;
        if (ctrl.move_done) begin
          fanfare_go = fan_flag;  // Single pulse on arrival
          nxt_state  = DECR;
        end else
          moving = 1'b1;
      end
      DECR: begin
        ctrl.dec_frwrd = 1'b1;
        if (ctrl.zero) begin    // Fully stopped
          send_resp = 1'b1;
          nxt_state = IDLE;
        end else
          moving = 1'b1;
      end
      default: nxt_state = IDLE;
    endcase
  end

endmodule

/* hdl/move_ctrl_if.sv */
`timescale 1ns/1ps

interface move_ctrl_if import knight_pkg::*; ();

  logic     load;       // Capture the move fields of cmd
  logic     clr_frwrd;  // Clear the speed register
  logic     inc_frwrd;  // Ramp speed up on heading updates
  logic     dec_frwrd;  // Ramp speed down on heading updates
  logic     move_done;  // Line count reached twice the squares
  logic     zero;       // Speed register is at rest
  heading_t error;      // Heading error toward the PID

  // Command FSM steers the data path
  modport fsm (output load, clr_frwrd, inc_frwrd, dec_frwrd,
               input  move_done, zero, error);

  modport counter (input load, output move_done);  // Square counting

  modport ramp (input clr_frwrd, inc_frwrd, dec_frwrd, output zero);  // Speed

  modport heading (input load, output error);  // Error to PID

endinterface

/* hdl/knight_pkg.sv */
package knight_pkg;

  ////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////
  typedef logic [15:0]        cmd_t;      // Command word from BLE
  typedef logic signed [11:0] heading_t;  // Gyro heading or heading error
  typedef logic [9:0]         frwrd_t;    // Forward speed to the PID
  typedef logic [2:0]         sq_cnt_t;   // Number of squares in a move

  ////////////////////////////////////////
  // Opcodes in cmd[15:12]
  ////////////////////////////////////////
  localparam logic [3:0] OP_CAL      = 4'h2;  // Start gyro calibration
  localparam logic [3:0] OP_TOUR     = 4'h6;  // Hand off to the tour sequencer
  localparam logic [3:0] OP_MOVE     = 4'h4;  // Plain move
  localparam logic [3:0] OP_MOVE_FAN = 4'h5;  // Move then play the fanfare

  // Speed steps per heading update, sized for short simulations
  localparam frwrd_t FRWRD_INC = 10'h020;  // Ramp up step
  localparam frwrd_t FRWRD_DEC = 10'h040;  // Ramp down step, twice as steep

  // Heading nudge from the side IR sensors
  localparam heading_t NUDGE_LFT  = 12'sh05F;   // Drifted onto left line
  localparam heading_t NUDGE_RGHT = -12'sh05F;  // Drifted onto right line

  // Error magnitude the heading must be inside before the robot rolls
  localparam heading_t ERR_WIN = 12'sh02C;

  ////////////////////////////////////////
  // Command FSM states
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,        // Waiting on cmd_rdy
    START_TOUR,  // One cycle to kick the tour sequencer
    CALIBRATE,   // Waiting on the gyro
    MOVE,        // Turning to the new heading
    INCR,        // Ramping up and counting lines
    DECR         // Ramping down to a stop
  } cmd_state_t;

endpackage
